// File: list.f
rtl/riscv_isa_pkg.sv
rtl/bp_pkg.sv
rtl/bu_decode.sv
rtl/bu_resolve.sv
rtl/bp_gshare.sv
rtl/bu_top.sv
testbench/bu_checker.sv
testbench/tb_bu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_bu -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_bu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: testbench/tb_bu.sv
module tb_bu
  import riscv_isa_pkg::*;
();

  localparam int unsigned SEED    = 17860;
  localparam int unsigned TIMEOUT = 40;
  localparam logic [2:0]  F3_LIST [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
  localparam logic [31:0] EXTREMES [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                           32'hffff_ffff};

  logic         clk_i, rst_ni, id_valid_i;
  logic [31:0]  id_pc_i, id_insn_i, opa_i, opb_i;
  logic         res_valid_o, res_taken_o, res_predict_o, res_flush_o;
  logic         res_misaligned_o, res_ic_invalidate_o, res_dc_clean_o;
  logic [31:0]  res_nxt_pc_o;
  logic [159:0] test_name;
  logic         test_end, run_done, aborted;
  int unsigned  pending, n_pass, n_fail;
  logic [31:0]  a, b, pc, insn;
  logic [12:0]  imm13;
  logic [20:0]  imm21;

  bu_top DUT (.*);

  bu_checker #(.TIMEOUT(TIMEOUT)) u_checker (
    .res_valid_i (res_valid_o),       .res_nxt_pc_i   (res_nxt_pc_o),
    .res_taken_i (res_taken_o),       .res_predict_i  (res_predict_o),
    .res_flush_i (res_flush_o),       .res_misaligned_i (res_misaligned_o),
    .res_ic_invalidate_i (res_ic_invalidate_o), .res_dc_clean_i (res_dc_clean_o),
    .test_name_i (test_name),         .test_end_i     (test_end),
    .done_i      (run_done),          .pending_o      (pending),
    .pass_cnt_o  (n_pass),            .fail_cnt_o     (n_fail),
    .*
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Overall cycle limit
  initial begin
    repeat (20000) @(posedge clk_i);
    $display("Simulation ran past its cycle limit");
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  function automatic logic [31:0] word_pc();
    return $urandom & 32'hffff_fffc;
  endfunction

  // Equal, sign-crossing, extreme or fully random operand pairs
  task automatic pick_operands(output logic [31:0] x, output logic [31:0] y);
    x = $urandom;
    y = $urandom;
    case ($urandom_range(4, 0))
      0: y = x;
      1: begin
        x = x | 32'h8000_0000;
        y = y & 32'h7fff_ffff;
      end
      2: begin
        x = x & 32'h7fff_ffff;
        y = y | 32'h8000_0000;
      end
      3: begin
        x = EXTREMES[$urandom_range(4, 0)];
        y = EXTREMES[$urandom_range(4, 0)];
      end
      default: y = $urandom;
    endcase
  endtask

  task automatic strobe(input logic [31:0] s_pc, s_insn, s_a, s_b, input int gap);
    @(posedge clk_i);
    id_valid_i <= 1'b1;
    id_pc_i    <= s_pc;
    id_insn_i  <= s_insn;
    opa_i      <= s_a;
    opb_i      <= s_b;
    repeat (gap) begin
      @(posedge clk_i);
      id_valid_i <= 1'b0;
    end
  endtask

  task automatic begin_test(input logic [159:0] name);
    @(posedge clk_i);
    test_name <= name;
  endtask

  // Drain outstanding results and then pulse the end of the test
  task automatic end_test();
    int unsigned waited;
    waited = 0;
    @(posedge clk_i);
    id_valid_i <= 1'b0;
    @(negedge clk_i);
    while (pending != 0 && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (pending != 0) begin
      $display("Results of %0s still outstanding after %0d cycles", test_name, TIMEOUT);
      aborted = 1'b1;
    end
    @(posedge clk_i);
    test_end <= 1'b1;
    @(posedge clk_i);
    test_end <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    id_valid_i = 1'b0;
    id_pc_i    = '0;
    id_insn_i  = '0;
    opa_i      = '0;
    opb_i      = '0;
    test_end   = 1'b0;
    run_done   = 1'b0;
    aborted    = 1'b0;
    test_name  = "cond_branches";
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test("cond_branches");
    for (int i = 0; i < 48; i++) begin
      pick_operands(a, b);
      imm13 = 13'($urandom) & 13'h1ffc;
      strobe(word_pc(), enc_branch(F3_LIST[$urandom_range(5, 0)], imm13), a, b,
             int'($urandom_range(2, 0)));
    end
    end_test();

    begin_test("jumps");
    for (int i = 0; i < 32; i++) begin
      imm21 = 21'($urandom) & 21'h1f_fffc;
      if ($urandom_range(1, 0) == 0) begin
        insn = enc_jal(imm21);
      end else begin
        insn = {12'($urandom), 5'd3, 3'b000, 5'd1, OPC_JALR};
      end
      strobe(word_pc(), insn, $urandom, $urandom, int'($urandom_range(2, 0)));
    end
    end_test();

    // Same branch PC taken eight times and then not taken eight times
    begin_test("predictor_training");
    for (int i = 0; i < 16; i++) begin
      a = $urandom;
      b = (i < 8) ? a : ~a;
      strobe(32'h0000_0150, enc_branch(F3_BEQ, 13'h0040), a, b, 0);
    end
    end_test();

    begin_test("misaligned_targets");
    for (int i = 0; i < 36; i++) begin
      pc = word_pc();
      if ($urandom_range(3, 0) == 0) begin
        pc[1:0] = 2'($urandom_range(3, 1));
      end
      pick_operands(a, b);
      imm13 = 13'($urandom) & 13'h1ffe;
      imm21 = 21'($urandom) & 21'h1f_fffe;
      case ($urandom_range(2, 0))
        0: insn = enc_branch(F3_LIST[$urandom_range(5, 0)], imm13);
        1: insn = enc_jal(imm21);
        default: insn = {12'($urandom), 5'd3, 3'b000, 5'd1, OPC_JALR};
      endcase
      strobe(pc, insn, a, b, int'($urandom_range(2, 0)));
    end
    end_test();

    begin_test("fence_and_others");
    // Two taken branches leave a nonzero history ahead of the other words
    for (int i = 0; i < 2; i++) begin
      strobe(32'h0000_0150, enc_branch(F3_BEQ, 13'h0040), 32'h5, 32'h5, 0);
    end
    // Bit 6 cleared keeps the word off the jump and branch opcodes
    for (int i = 0; i < 24; i++) begin
      insn = $urandom & 32'hffff_ffbf;
      if (i % 3 == 0) begin
        insn = FENCE_I_INSN;
      end
      strobe(word_pc(), insn, $urandom, $urandom, int'($urandom_range(2, 0)));
    end
    for (int i = 0; i < 4; i++) begin
      strobe(32'h0000_0150, enc_branch(F3_BNE, 13'h0040), 32'h1, 32'h1, 0);
    end
    end_test();

    begin_test("reset_state");
    // FENCE.I result holds flush and the cache outputs high into the reset
    strobe(word_pc(), FENCE_I_INSN, 32'h0, 32'h0, 1);
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    end_test();

    @(posedge clk_i);
    run_done <= 1'b1;
    @(posedge clk_i);
    run_done <= 1'b0;
    @(negedge clk_i);
    if (aborted || n_fail != 0 || n_pass != 6) begin
      $display("test failed");
    end else begin
      $display("test passed");
    end
    $finish;
  end

endmodule

// File: testbench/bu_checker.sv
module bu_checker
  import riscv_isa_pkg::*;
  import bp_pkg::*;
#(
  parameter int unsigned TIMEOUT = 40
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         id_valid_i,
  input  logic [31:0]  id_pc_i,
  input  logic [31:0]  id_insn_i,
  input  logic [31:0]  opa_i,
  input  logic [31:0]  opb_i,
  input  logic         res_valid_i,
  input  logic [31:0]  res_nxt_pc_i,
  input  logic         res_taken_i,
  input  logic         res_predict_i,
  input  logic         res_flush_i,
  input  logic         res_misaligned_i,
  input  logic         res_ic_invalidate_i,
  input  logic         res_dc_clean_i,
  input  logic [159:0] test_name_i,
  input  logic         test_end_i,
  input  logic         done_i,
  output int unsigned  pending_o,
  output int unsigned  pass_cnt_o,
  output int unsigned  fail_cnt_o
);

  typedef struct packed {
    logic [31:0] nxt_pc;
    logic        taken;
    logic        predict;
    logic        flush;
    logic        misaligned;
    logic        cache_op;
    logic [31:0] edge_no;
  } expect_t;

  expect_t                   exp_q [$];
  expect_t                   cur;
  expect_t                   e;
  logic [1:0]                cnt [BP_ENTRIES];
  logic [BP_GLOBAL_BITS-1:0] hist;
  logic [BP_INDEX_BITS-1:0]  idx;
  branch_op_t                op;
  logic                      cbr;
  logic                      in_reset = 1'b0;
  logic [31:0]               edge_no = '0;
  int unsigned               checks = 0;
  int unsigned               errors = 0;
  int unsigned               n_pass = 0;
  int unsigned               n_fail = 0;
  int unsigned               n_pending = 0;
  string                     first_msg = "";

  assign pending_o  = n_pending;
  assign pass_cnt_o = n_pass;
  assign fail_cnt_o = n_fail;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic branch_op_t model_op(input logic [31:0] w);
    if (w == FENCE_I_INSN) return BR_FENCE_I;
    if (w[6:0] == OPC_JAL) return BR_JAL;
    if (w[6:0] == OPC_JALR) return BR_JALR;
    if (w[6:0] != OPC_BRANCH) return BR_NONE;
    case (w[14:12])
      F3_BEQ:  return BR_BEQ;
      F3_BNE:  return BR_BNE;
      F3_BLT:  return BR_BLT;
      F3_BGE:  return BR_BGE;
      F3_BLTU: return BR_BLTU;
      F3_BGEU: return BR_BGEU;
      default: return BR_NONE;
    endcase
  endfunction

  function automatic logic model_taken(input branch_op_t o, input logic [31:0] x, y);
    case (o)
      BR_BEQ:          return x == y;
      BR_BNE:          return x != y;
      BR_BLT:          return $signed(x) < $signed(y);
      BR_BGE:          return !($signed(x) < $signed(y));
      BR_BLTU:         return x < y;
      BR_BGEU:         return !(x < y);
      BR_JAL, BR_JALR: return 1'b1;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic model_strobe();
    op        = model_op(id_insn_i);
    cbr       = op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    idx       = id_pc_i[BP_INDEX_BITS+1:2] ^ BP_INDEX_BITS'(hist);
    e.predict = cnt[idx][1];
    e.taken   = model_taken(op, opa_i, opb_i);
    if (op == BR_JAL) begin
      e.nxt_pc = id_pc_i + {{12{id_insn_i[31]}}, id_insn_i[19:12], id_insn_i[20],
                            id_insn_i[30:21], 1'b0};
    end else if (op == BR_JALR) begin
      e.nxt_pc = (opa_i + opb_i) & 32'hffff_fffe;
    end else if (cbr && e.taken) begin
      e.nxt_pc = id_pc_i + {{20{id_insn_i[31]}}, id_insn_i[7], id_insn_i[30:25],
                            id_insn_i[11:8], 1'b0};
    end else begin
      e.nxt_pc = id_pc_i + 32'd4;
    end
    if (cbr) begin
      e.flush = e.taken ^ e.predict;
    end else begin
      e.flush = (op == BR_JAL) ? !e.predict : (op == BR_JALR || op == BR_FENCE_I);
    end
    e.misaligned = (cbr || op == BR_JAL || op == BR_JALR) && (e.nxt_pc[1:0] != 2'b00);
    e.cache_op   = (op == BR_FENCE_I);
    e.edge_no    = edge_no;
    exp_q.push_back(e);
    // Saturating counter step and history shift, same index as the lookup
    if (cbr) begin
      if (e.taken && cnt[idx] != 2'd3) begin
        cnt[idx] = cnt[idx] + 2'd1;
      end else if (!e.taken && cnt[idx] != 2'd0) begin
        cnt[idx] = cnt[idx] - 2'd1;
      end
      hist = {hist[BP_GLOBAL_BITS-2:0], e.taken};
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Comparison and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic record_error(input string msg);
    errors++;
    if (first_msg.len() == 0) begin
      first_msg = msg;
    end
  endtask

  task automatic compare_field(input string field, input logic [31:0] exp_v, act_v);
    checks++;
    if (exp_v !== act_v) begin
      record_error($sformatf("Fail %0s: %0s expected 0x%08h actual 0x%08h",
                             test_name_i, field, exp_v, act_v));
    end
  endtask

  task automatic collect_result();
    if (res_valid_i) begin
      if (exp_q.size() == 0) begin
        record_error($sformatf("%0s: a result appeared with no strobe waiting for it",
                               test_name_i));
      end else begin
        cur = exp_q.pop_front();
        if (edge_no != cur.edge_no + 32'd1) begin
          record_error($sformatf("%0s: a result came %0d cycles after its strobe, not 1",
                                 test_name_i, edge_no - cur.edge_no));
        end
        compare_field("res_nxt_pc_o", cur.nxt_pc, res_nxt_pc_i);
        compare_field("res_taken_o", 32'(cur.taken), 32'(res_taken_i));
        compare_field("res_predict_o", 32'(cur.predict), 32'(res_predict_i));
        compare_field("res_flush_o", 32'(cur.flush), 32'(res_flush_i));
        compare_field("res_misaligned_o", 32'(cur.misaligned), 32'(res_misaligned_i));
        compare_field("res_ic_invalidate_o", 32'(cur.cache_op), 32'(res_ic_invalidate_i));
        compare_field("res_dc_clean_o", 32'(cur.cache_op), 32'(res_dc_clean_i));
      end
    end else if (exp_q.size() != 0 && edge_no - exp_q[0].edge_no > TIMEOUT) begin
      record_error($sformatf("%0s: no result arrived within %0d cycles of a strobe",
                             test_name_i, TIMEOUT));
      cur = exp_q.pop_front();
    end
  endtask

  always @(posedge clk_i) begin
    edge_no = edge_no + 32'd1;
    if (!rst_ni) begin
      for (int i = 0; i < BP_ENTRIES; i++) begin
        cnt[i] = CNT_WEAK_NT;
      end
      hist = '0;
      exp_q.delete();
      in_reset = 1'b1;
    end else begin
      // First edge after reset release sees the reset values
      if (in_reset) begin
        compare_field("reset res_valid_o", 32'd0, 32'(res_valid_i));
        compare_field("reset res_flush_o", 32'd0, 32'(res_flush_i));
        compare_field("reset res_ic_invalidate_o", 32'd0, 32'(res_ic_invalidate_i));
        compare_field("reset res_dc_clean_o", 32'd0, 32'(res_dc_clean_i));
        compare_field("reset res_nxt_pc_o", PC_INIT, res_nxt_pc_i);
        in_reset = 1'b0;
      end
      collect_result();
      if (id_valid_i) begin
        model_strobe();
      end
    end
    if (test_end_i) begin
      if (errors == 0) begin
        $display("ok   %0s: %0d checks", test_name_i, checks);
        n_pass++;
      end else begin
        $display("%0s (%0d errors in %0d checks)", first_msg, errors, checks);
        n_fail++;
      end
      checks    = 0;
      errors    = 0;
      first_msg = "";
    end
    if (done_i) begin
      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    end
    n_pending = exp_q.size();
  end

endmodule

// File: rtl/bu_top.sv
module bu_top
  import riscv_isa_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            id_valid_i,
  input  logic [XLEN-1:0] id_pc_i,
  input  logic [31:0]     id_insn_i,
  input  logic [XLEN-1:0] opa_i,
  input  logic [XLEN-1:0] opb_i,

  output logic            res_valid_o,
  output logic [XLEN-1:0] res_nxt_pc_o,
  output logic            res_taken_o,
  output logic            res_predict_o,
  output logic            res_flush_o,
  output logic            res_misaligned_o,
  output logic            res_ic_invalidate_o,
  output logic            res_dc_clean_o
);

  branch_op_t      op;
  logic [XLEN-1:0] imm;
  logic            predict;
  logic            bp_update;
  logic            bp_taken;

  bu_decode u_decode (
    .id_insn_i (id_insn_i),
    .op_o      (op),
    .imm_o     (imm)
  );

  bu_resolve u_resolve (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .id_valid_i          (id_valid_i),
    .id_pc_i             (id_pc_i),
    .opa_i               (opa_i),
    .opb_i               (opb_i),
    .op_i                (op),
    .imm_i               (imm),
    .predict_i           (predict),
    .bp_update_o         (bp_update),
    .bp_taken_o          (bp_taken),
    .res_valid_o         (res_valid_o),
    .res_nxt_pc_o        (res_nxt_pc_o),
    .res_taken_o         (res_taken_o),
    .res_predict_o       (res_predict_o),
    .res_flush_o         (res_flush_o),
    .res_misaligned_o    (res_misaligned_o),
    .res_ic_invalidate_o (res_ic_invalidate_o),
    .res_dc_clean_o      (res_dc_clean_o)
  );

  // Lookup and training both key on the strobe PC
  bp_gshare u_gshare (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pc_i      (id_pc_i),
    .predict_o (predict),
    .update_i  (bp_update),
    .taken_i   (bp_taken)
  );

endmodule

// File: rtl/bp_gshare.sv
module bp_gshare
  import bp_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] pc_i,
  output logic        predict_o,
  input  logic        update_i,
  input  logic        taken_i
);

  logic [BP_GLOBAL_BITS-1:0] hist_q;
  logic [BP_INDEX_BITS-1:0]  idx;
  bp_cnt_t                   cnt_q [BP_ENTRIES];
  bp_cnt_t                   cnt_rd;
  bp_cnt_t                   cnt_nxt;

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  // Word index with the history folded into its low bits
  assign idx = pc_i[BP_INDEX_BITS+1:2] ^
               {{(BP_INDEX_BITS-BP_GLOBAL_BITS){1'b0}}, hist_q};

  assign cnt_rd    = cnt_q[idx];
  assign predict_o = (cnt_rd == CNT_WEAK_T) || (cnt_rd == CNT_STRONG_T);

  //////////////////////////////////////////////////////////////////////
  // Training
  //////////////////////////////////////////////////////////////////////

  // One saturating step toward the outcome
  always_comb begin
    case (cnt_rd)
      CNT_STRONG_NT: cnt_nxt = taken_i ? CNT_WEAK_NT  : CNT_STRONG_NT;
      CNT_WEAK_NT:   cnt_nxt = taken_i ? CNT_WEAK_T   : CNT_STRONG_NT;
      CNT_WEAK_T:    cnt_nxt = taken_i ? CNT_STRONG_T : CNT_WEAK_NT;
      CNT_STRONG_T:  cnt_nxt = taken_i ? CNT_STRONG_T : CNT_WEAK_T;
      default:       cnt_nxt = CNT_WEAK_NT;
    endcase
  end

  // Same index as the lookup, so the entry that predicted is trained
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < BP_ENTRIES; i++) begin
        cnt_q[i] <= CNT_WEAK_NT;
      end
    end else if (update_i) begin
      cnt_q[idx] <= cnt_nxt;
    end
  end

  // Global history, newest outcome in bit 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '0;
    end else if (update_i) begin
      hist_q <= {hist_q[BP_GLOBAL_BITS-2:0], taken_i};
    end
  end

endmodule

// File: rtl/bu_resolve.sv
module bu_resolve
  import riscv_isa_pkg::*;
  import bp_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // Strobe from the decode stage
  input  logic            id_valid_i,
  input  logic [XLEN-1:0] id_pc_i,
  input  logic [XLEN-1:0] opa_i,
  input  logic [XLEN-1:0] opb_i,
  input  branch_op_t      op_i,
  input  logic [XLEN-1:0] imm_i,

  // Predictor lookup and training
  input  logic            predict_i,
  output logic            bp_update_o,
  output logic            bp_taken_o,

  // Registered result
  output logic            res_valid_o,
  output logic [XLEN-1:0] res_nxt_pc_o,
  output logic            res_taken_o,
  output logic            res_predict_o,
  output logic            res_flush_o,
  output logic            res_misaligned_o,
  output logic            res_ic_invalidate_o,
  output logic            res_dc_clean_o
);

  logic            is_cbr;
  logic            is_jump;
  logic            is_fence_i;
  logic            taken;
  logic            flush;
  logic            misaligned;
  logic [XLEN-1:0] pc_seq;
  logic [XLEN-1:0] pc_rel;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] nxt_pc;

  //////////////////////////////////////////////////////////////////////
  // Branch condition
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    is_cbr = 1'b1;
    case (op_i)
      BR_BEQ:  taken = (opa_i == opb_i);
      BR_BNE:  taken = (opa_i != opb_i);
      BR_BLT:  taken = ($signed(opa_i) < $signed(opb_i));
      BR_BGE:  taken = ($signed(opa_i) >= $signed(opb_i));
      BR_BLTU: taken = (opa_i < opb_i);
      BR_BGEU: taken = (opa_i >= opb_i);
      default: begin
        is_cbr = 1'b0;
        // Unconditional jumps always redirect
        taken  = (op_i == BR_JAL) || (op_i == BR_JALR);
      end
    endcase
  end

  assign is_jump    = (op_i == BR_JAL) || (op_i == BR_JALR);
  assign is_fence_i = (op_i == BR_FENCE_I);

  //////////////////////////////////////////////////////////////////////
  // Next PC, flush and alignment
  //////////////////////////////////////////////////////////////////////

  // No RVC, every instruction is one word
  assign pc_seq   = id_pc_i + XLEN'(4);
  assign pc_rel   = id_pc_i + imm_i;
  assign jalr_sum = opa_i + opb_i;

  always_comb begin
    case (op_i)
      BR_JAL:  nxt_pc = pc_rel;
      BR_JALR: nxt_pc = {jalr_sum[XLEN-1:1], 1'b0};
      default: nxt_pc = (is_cbr && taken) ? pc_rel : pc_seq;
    endcase
  end

  // Flush when the front end followed the wrong path
  always_comb begin
    case (op_i)
      BR_JAL:              flush = ~predict_i;
      BR_JALR, BR_FENCE_I: flush = 1'b1;
      default:             flush = is_cbr & (taken ^ predict_i);
    endcase
  end

  assign misaligned = (is_cbr || is_jump) && (|nxt_pc[1:0]);

  // Train only on conditional branches of a real strobe
  assign bp_update_o = id_valid_i & is_cbr;
  assign bp_taken_o  = taken;

  //////////////////////////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o         <= 1'b0;
      res_nxt_pc_o        <= PC_INIT;
      res_taken_o         <= 1'b0;
      res_predict_o       <= 1'b0;
      res_flush_o         <= 1'b0;
      res_misaligned_o    <= 1'b0;
      res_ic_invalidate_o <= 1'b0;
      res_dc_clean_o      <= 1'b0;
    end else begin
      res_valid_o <= id_valid_i;
      // Fields hold between strobes
      if (id_valid_i) begin
        res_nxt_pc_o        <= nxt_pc;
        res_taken_o         <= taken;
        res_predict_o       <= predict_i;
        res_flush_o         <= flush;
        res_misaligned_o    <= misaligned;
        res_ic_invalidate_o <= is_fence_i;
        res_dc_clean_o      <= is_fence_i;
      end
    end
  end

endmodule

// File: rtl/bu_decode.sv
module bu_decode
  import riscv_isa_pkg::*;
(
  input  logic [31:0]     id_insn_i,
  output branch_op_t      op_o,
  output logic [XLEN-1:0] imm_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;

  assign opcode = id_insn_i[6:0];
  assign funct3 = id_insn_i[14:12];

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  // J-type, imm[20|10:1|11|19:12]
  assign imm_j = {{(XLEN-20){id_insn_i[31]}},
                  id_insn_i[19:12],
                  id_insn_i[20],
                  id_insn_i[30:21],
                  1'b0};

  // B-type, imm[12|10:5] and imm[4:1|11]
  assign imm_b = {{(XLEN-12){id_insn_i[31]}},
                  id_insn_i[7],
                  id_insn_i[30:25],
                  id_insn_i[11:8],
                  1'b0};

  //////////////////////////////////////////////////////////////////////
  // Operation classification
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    op_o = BR_NONE;
    case (opcode)
      OPC_JAL:  op_o = BR_JAL;
      OPC_JALR: op_o = BR_JALR;
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ:  op_o = BR_BEQ;
          F3_BNE:  op_o = BR_BNE;
          F3_BLT:  op_o = BR_BLT;
          F3_BGE:  op_o = BR_BGE;
          F3_BLTU: op_o = BR_BLTU;
          F3_BGEU: op_o = BR_BGEU;
          // Reserved encodings 010 and 011
          default: op_o = BR_NONE;
        endcase
      end
      OPC_MISCMEM: begin
        // Only the exact FENCE.I word, plain FENCE is not a branch
        if (id_insn_i == FENCE_I_INSN) begin
          op_o = BR_FENCE_I;
        end
      end
      default: op_o = BR_NONE;
    endcase
  end

  // Immediate follows the decoded operation, zero when unused
  always_comb begin
    case (op_o)
      BR_JAL: imm_o = imm_j;
      BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU: begin
        imm_o = imm_b;
      end
      default: imm_o = '0;
    endcase
  end

endmodule

// File: rtl/bp_pkg.sv
package bp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Predictor geometry
  //////////////////////////////////////////////////////////////////////

  // Table index width and entry count
  localparam int BP_INDEX_BITS = 6;
  localparam int BP_ENTRIES    = 2 ** BP_INDEX_BITS;

  // Global history length, folded into the low index bits
  localparam int BP_GLOBAL_BITS = 2;

  // Next PC presented after reset
  localparam logic [31:0] PC_INIT = 32'h0000_0200;

  // Two-bit saturating counter, top bit is the prediction
  typedef enum logic [1:0] {
    CNT_STRONG_NT = 2'd0,
    CNT_WEAK_NT   = 2'd1,
    CNT_WEAK_T    = 2'd2,
    CNT_STRONG_T  = 2'd3
  } bp_cnt_t;

endpackage

// File: rtl/riscv_isa_pkg.sv
package riscv_isa_pkg;

  //////////////////////////////////////////////////////////////////////
  // Machine width
  //////////////////////////////////////////////////////////////////////

  // Data and address width, one word
  localparam int XLEN = 32;

  //////////////////////////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_JAL     = 7'b110_1111;
  localparam logic [6:0] OPC_JALR    = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH  = 7'b110_0011;
  localparam logic [6:0] OPC_MISCMEM = 7'b000_1111;

  //////////////////////////////////////////////////////////////////////
  // Conditional branch funct3 codes
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Full FENCE.I word, funct3 001 with all other fields zero
  localparam logic [31:0] FENCE_I_INSN = 32'h0000_100f;

  //////////////////////////////////////////////////////////////////////
  // Resolved branch operations
  //////////////////////////////////////////////////////////////////////

  // BR_NONE covers every instruction that does not redirect the PC
  typedef enum logic [3:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_FENCE_I
  } branch_op_t;

endpackage
